/* rtl/ahb_bridge_pkg.sv */
// AHB-to-AXI bridge front end shared types
// Bus encodings, FSM states and the beat count type
`default_nettype none

package ahb_bridge_pkg;

  // ------------------------------------------------------------
  // AHB-Lite encodings
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    TRANS_IDLE   = 2'b00,
    TRANS_BUSY   = 2'b01,
    TRANS_NONSEQ = 2'b10,  // First beat of any transfer
    TRANS_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    BURST_SINGLE = 3'b000,
    BURST_INCR   = 3'b001,  // Undefined length, treated as one beat
    BURST_WRAP4  = 3'b010,
    BURST_INCR4  = 3'b011,
    BURST_WRAP8  = 3'b100,
    BURST_INCR8  = 3'b101,
    BURST_WRAP16 = 3'b110,
    BURST_INCR16 = 3'b111
  } hburst_e;

  typedef enum logic {
    RESP_OKAY  = 1'b0,
    RESP_ERROR = 1'b1
  } hresp_e;

  // Back-end write response, AXI style
  typedef enum logic [1:0] {
    AXI_OKAY   = 2'b00,
    AXI_EXOKAY = 2'b01,
    AXI_SLVERR = 2'b10,
    AXI_DECERR = 2'b11
  } axi_resp_e;

  // ------------------------------------------------------------
  // Access FSM
  // ------------------------------------------------------------
  typedef enum logic [2:0] {
    ST_IDLE    = 3'd0,
    ST_WR_DATA = 3'd1,
    ST_WR_RESP = 3'd2,
    ST_WR_ERR  = 3'd3,
    ST_RD_WAIT = 3'd4,
    ST_RD_DATA = 3'd5
  } access_state_e;

  localparam int BEAT_CNT_W = 4;
  typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;  // Beats minus one

endpackage

`default_nettype wire

/* rtl/ahb_cmd_capture.sv */
// AHB-Lite address phase capture
// Flags new transfers and holds the command fields for the back end
`default_nettype none

module ahb_cmd_capture #(
  parameter int AHB_AWIDTH = 32
) (
  input  wire                          HCLK,
  input  wire                          HRESETn,
  input  wire                          HSEL,
  input  wire                          HREADY,
  input  var ahb_bridge_pkg::htrans_e  HTRANS,
  input  wire                          HWRITE,
  input  wire [AHB_AWIDTH-1:0]         HADDR,
  input  wire [2:0]                    HSIZE,
  input  var ahb_bridge_pkg::hburst_e  HBURST,
  input  wire                          accept,
  output logic                         xfer_valid,
  output logic [AHB_AWIDTH-1:0]        cmd_addr,
  output logic                         cmd_write,
  output logic [2:0]                   cmd_size,
  output ahb_bridge_pkg::beat_cnt_t    cmd_len
);

  ahb_bridge_pkg::beat_cnt_t len_dec;  // Beat count of the current address phase

  // Only NONSEQ starts a command, SEQ beats ride on the burst
  assign xfer_valid = HSEL && HREADY && (HTRANS == ahb_bridge_pkg::TRANS_NONSEQ);

  // ------------------------------------------------------------
  // Burst length decode
  // ------------------------------------------------------------
  always_comb begin
    case (HBURST)
      ahb_bridge_pkg::BURST_WRAP16,
      ahb_bridge_pkg::BURST_INCR16: len_dec = ahb_bridge_pkg::beat_cnt_t'(15);
      ahb_bridge_pkg::BURST_WRAP8,
      ahb_bridge_pkg::BURST_INCR8:  len_dec = ahb_bridge_pkg::beat_cnt_t'(7);
      ahb_bridge_pkg::BURST_WRAP4,
      ahb_bridge_pkg::BURST_INCR4:  len_dec = ahb_bridge_pkg::beat_cnt_t'(3);
      default:                      len_dec = '0;  // SINGLE and INCR, one beat
    endcase
  end

  // Direction and length steer the FSM
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      cmd_write <= 1'b0;
      cmd_len   <= '0;
    end else if (accept) begin
      cmd_write <= HWRITE;
      cmd_len   <= len_dec;
    end
  end

  // Address and size only travel to the back end
  always_ff @(posedge HCLK) begin
    if (accept) begin
      cmd_addr <= HADDR;
      cmd_size <= HSIZE;
    end
  end

  // Bursts are never paused by the master
  no_busy_xfer: assert property (@(posedge HCLK) disable iff (!HRESETn)
    HSEL |-> (HTRANS != ahb_bridge_pkg::TRANS_BUSY))
    else $error("BUSY transfer seen on a selected slave");

endmodule

`default_nettype wire

/* rtl/ahb_access_fsm.sv */
// AHB access state machine
// Drives HREADYOUT/HRESP, counts beats and runs the command req/ack
`default_nettype none

module ahb_access_fsm (
  input  wire                            HCLK,
  input  wire                            HRESETn,
  input  wire                            xfer_valid,
  input  wire                            HWRITE,
  input  wire                            cmd_write,
  input  wire ahb_bridge_pkg::beat_cnt_t cmd_len,
  input  wire                            wr_full,
  input  wire                            rd_empty,
  input  wire                            rd_data_valid,
  input  wire                            cmd_ack,
  input  wire                            bresp_valid,
  input  var ahb_bridge_pkg::axi_resp_e  bresp,
  output logic                           accept,
  output logic                           HREADYOUT,
  output ahb_bridge_pkg::hresp_e         hresp,
  output logic                           wr_push,
  output logic                           rd_pop,
  output logic                           cmd_req
);

  ahb_bridge_pkg::access_state_e state;
  ahb_bridge_pkg::access_state_e state_nxt;
  ahb_bridge_pkg::beat_cnt_t     beat_cnt;  // Index of the beat in progress

  logic hs_done;    // Four-phase handshake back at rest
  logic last_beat;
  logic next_last;  // Beat after this one is the last
  logic done_cyc;   // HREADYOUT high that ends the transfer
  logic beat_inc;
  logic resp_seen;  // bresp received, waiting to be returned
  logic resp_err;

  assign hs_done   = !cmd_req && !cmd_ack;
  assign last_beat = (beat_cnt == cmd_len);
  assign next_last = ((beat_cnt + 1'b1) == cmd_len);

  // New transfers only when idle or on the closing beat
  assign accept = xfer_valid && ((state == ahb_bridge_pkg::ST_IDLE) || done_cyc);

  // ------------------------------------------------------------
  // Outputs per state
  // ------------------------------------------------------------
  always_comb begin
    HREADYOUT = 1'b0;
    hresp     = ahb_bridge_pkg::RESP_OKAY;
    wr_push   = 1'b0;
    rd_pop    = 1'b0;
    done_cyc  = 1'b0;
    beat_inc  = 1'b0;
    case (state)
      ahb_bridge_pkg::ST_IDLE: HREADYOUT = 1'b1;
      ahb_bridge_pkg::ST_WR_DATA: begin
        wr_push   = !wr_full;                // Back-pressure while full
        HREADYOUT = !wr_full && !last_beat;  // Last beat held until bresp
        beat_inc  = !wr_full && !last_beat;
      end
      ahb_bridge_pkg::ST_WR_RESP: begin
        if (resp_seen && hs_done) begin
          if (resp_err) begin
            hresp = ahb_bridge_pkg::RESP_ERROR;  // First ERROR cycle, not ready
          end else begin
            HREADYOUT = 1'b1;
            done_cyc  = 1'b1;
          end
        end
      end
      ahb_bridge_pkg::ST_WR_ERR: begin
        HREADYOUT = 1'b1;
        hresp     = ahb_bridge_pkg::RESP_ERROR;
        done_cyc  = 1'b1;
      end
      ahb_bridge_pkg::ST_RD_WAIT: begin
        // Last word only once the command handshake has closed
        rd_pop = !rd_empty && (!last_beat || hs_done);
      end
      ahb_bridge_pkg::ST_RD_DATA: begin
        if (rd_data_valid) begin
          HREADYOUT = 1'b1;                  // HRDATA loaded last cycle
          if (last_beat) begin
            done_cyc = 1'b1;
          end else begin
            beat_inc = 1'b1;
            rd_pop   = !rd_empty && (!next_last || hs_done);  // Back-to-back beats
          end
        end
      end
      default: ;
    endcase
  end

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    if (accept) begin
      state_nxt = HWRITE ? ahb_bridge_pkg::ST_WR_DATA : ahb_bridge_pkg::ST_RD_WAIT;
    end else if (done_cyc) begin
      state_nxt = ahb_bridge_pkg::ST_IDLE;
    end else begin
      case (state)
        ahb_bridge_pkg::ST_WR_DATA:
          if (wr_push && last_beat) state_nxt = ahb_bridge_pkg::ST_WR_RESP;
        ahb_bridge_pkg::ST_WR_RESP:  // OKAY ends through done_cyc
          if (resp_seen && hs_done) state_nxt = ahb_bridge_pkg::ST_WR_ERR;
        ahb_bridge_pkg::ST_RD_WAIT:
          if (rd_pop) state_nxt = ahb_bridge_pkg::ST_RD_DATA;
        ahb_bridge_pkg::ST_RD_DATA:
          if (rd_data_valid && !rd_pop) state_nxt = ahb_bridge_pkg::ST_RD_WAIT;
        default: ;
      endcase
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state     <= ahb_bridge_pkg::ST_IDLE;
      beat_cnt  <= '0;
      cmd_req   <= 1'b0;
      resp_seen <= 1'b0;
      resp_err  <= 1'b0;
    end else begin
      state <= state_nxt;
      if (accept) begin
        beat_cnt <= '0;
      end else if (beat_inc) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
      // Four-phase req, raised with the address latch
      if (accept) begin
        cmd_req <= 1'b1;
      end else if (cmd_ack) begin
        cmd_req <= 1'b0;
      end
      // Only a write command takes a response
      if (bresp_valid && cmd_write) begin
        resp_seen <= 1'b1;
        resp_err  <= (bresp != ahb_bridge_pkg::AXI_OKAY);  // Only OKAY succeeds
      end else if ((state == ahb_bridge_pkg::ST_WR_RESP) && (state_nxt != state)) begin
        resp_seen <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // Checks on the handshake and the back end
  // ------------------------------------------------------------
  req_held_until_ack: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $fell(cmd_req) |-> $past(cmd_ack))
    else $error("cmd_req fell before cmd_ack");

  bresp_in_wr_resp: assert property (@(posedge HCLK) disable iff (!HRESETn)
    bresp_valid |-> (state == ahb_bridge_pkg::ST_WR_RESP))
    else $error("bresp_valid outside WR_RESP");

endmodule

`default_nettype wire

/* rtl/ahb_wr_buffer.sv */
// Write channel FIFO
// Filled from HWDATA by the FSM, drained by the back end, first-word fall-through
`default_nettype none

module ahb_wr_buffer #(
  parameter int AHB_DWIDTH = 32,
  parameter int FIFO_DEPTH = 4
) (
  input  wire                    HCLK,
  input  wire                    HRESETn,
  input  wire [AHB_DWIDTH-1:0]   HWDATA,
  input  wire                    wr_push,
  input  wire                    wr_pop,
  output logic [AHB_DWIDTH-1:0]  wr_data,
  output logic                   wr_empty,
  output logic                   wr_full
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic [AHB_DWIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W:0]        wptr;  // Extra MSB separates full from empty
  logic [PTR_W:0]        rptr;

  // ------------------------------------------------------------
  // Pointers
  // ------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (wr_push) begin
        wptr <= wptr + 1'b1;
      end
      if (wr_pop) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  // Data phase ends on this edge
  always_ff @(posedge HCLK) begin
    if (wr_push) begin
      mem[wptr[PTR_W-1:0]] <= HWDATA;
    end
  end

  assign wr_data  = mem[rptr[PTR_W-1:0]];  // Oldest word always visible
  assign wr_empty = (wptr == rptr);
  assign wr_full  = (wptr[PTR_W] != rptr[PTR_W]) &&
                    (wptr[PTR_W-1:0] == rptr[PTR_W-1:0]);

  // Back end must not underrun
  no_pop_empty: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wr_pop |-> !wr_empty)
    else $error("Write FIFO popped while empty");

endmodule

`default_nettype wire

/* rtl/ahb_rd_buffer.sv */
// Read channel FIFO
// Filled by the back end, each pop loads the registered HRDATA
`default_nettype none

module ahb_rd_buffer #(
  parameter int AHB_DWIDTH = 32,
  parameter int FIFO_DEPTH = 4
) (
  input  wire                    HCLK,
  input  wire                    HRESETn,
  input  wire                    rd_push,
  input  wire [AHB_DWIDTH-1:0]   rd_push_data,
  input  wire                    rd_pop,
  output logic                   rd_full,
  output logic                   rd_empty,
  output logic [AHB_DWIDTH-1:0]  HRDATA,
  output logic                   rd_data_valid
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic [AHB_DWIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W:0]        wptr;  // Wrap bit on top
  logic [PTR_W:0]        rptr;

  // ------------------------------------------------------------
  // Pointers and valid flag
  // ------------------------------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wptr          <= '0;
      rptr          <= '0;
      rd_data_valid <= 1'b0;
    end else begin
      if (rd_push) begin
        wptr <= wptr + 1'b1;
      end
      if (rd_pop) begin
        rptr <= rptr + 1'b1;
      end
      rd_data_valid <= rd_pop;  // High in the beat's ready cycle
    end
  end

  always_ff @(posedge HCLK) begin
    if (rd_push) begin
      mem[wptr[PTR_W-1:0]] <= rd_push_data;
    end
  end

  // HRDATA holds until the next pop
  always_ff @(posedge HCLK) begin
    if (rd_pop) begin
      HRDATA <= mem[rptr[PTR_W-1:0]];
    end
  end

  assign rd_empty = (wptr == rptr);
  assign rd_full  = (wptr[PTR_W] != rptr[PTR_W]) &&
                    (wptr[PTR_W-1:0] == rptr[PTR_W-1:0]);

  // Back end watches rd_full
  no_push_full: assert property (@(posedge HCLK) disable iff (!HRESETn)
    rd_push |-> !rd_full)
    else $error("Read FIFO pushed while full");

endmodule

`default_nettype wire

/* rtl/ahb_to_axi_front.sv */
// AHB-Lite slave front end of the AHB-to-AXI bridge
// Capture, access FSM and the two channel FIFOs
`default_nettype none

module ahb_to_axi_front #(
  parameter int AHB_AWIDTH = 32,
  parameter int AHB_DWIDTH = 32,
  parameter int FIFO_DEPTH = 4
) (
  input  wire                            HCLK,
  input  wire                            HRESETn,
  // AHB-Lite slave
  input  wire                            HSEL,
  input  wire [AHB_AWIDTH-1:0]           HADDR,
  input  wire                            HWRITE,
  input  wire                            HREADY,
  input  var ahb_bridge_pkg::htrans_e    HTRANS,
  input  wire [2:0]                      HSIZE,
  input  var ahb_bridge_pkg::hburst_e    HBURST,
  input  wire [AHB_DWIDTH-1:0]           HWDATA,
  output logic                           HREADYOUT,
  output logic [1:0]                     HRESP,
  output logic [AHB_DWIDTH-1:0]          HRDATA,
  // Command, four-phase
  output logic [AHB_AWIDTH-1:0]          cmd_addr,
  output logic                           cmd_write,
  output logic [2:0]                     cmd_size,
  output ahb_bridge_pkg::beat_cnt_t      cmd_len,
  output logic                           cmd_req,
  input  wire                            cmd_ack,
  // Write data and response
  output logic [AHB_DWIDTH-1:0]          wr_data,
  output logic                           wr_empty,
  input  wire                            wr_pop,
  input  wire                            bresp_valid,
  input  var ahb_bridge_pkg::axi_resp_e  bresp,
  // Read data
  input  wire                            rd_push,
  input  wire [AHB_DWIDTH-1:0]           rd_push_data,
  output logic                           rd_full
);

  logic                   xfer_valid;
  logic                   accept;
  logic                   wr_push;
  logic                   wr_full;
  logic                   rd_pop;
  logic                   rd_empty;
  logic                   rd_data_valid;
  ahb_bridge_pkg::hresp_e hresp;

  assign HRESP = {1'b0, hresp};  // AHB-Lite only uses the low bit

  // ------------------------------------------------------------
  // Blocks
  // ------------------------------------------------------------
  ahb_cmd_capture #(.AHB_AWIDTH(AHB_AWIDTH)) u_capture (
    .HCLK, .HRESETn, .HSEL, .HREADY, .HTRANS, .HWRITE, .HADDR, .HSIZE, .HBURST,
    .accept, .xfer_valid, .cmd_addr, .cmd_write, .cmd_size, .cmd_len
  );

  ahb_access_fsm u_fsm (
    .HCLK, .HRESETn, .xfer_valid, .HWRITE, .cmd_write, .cmd_len,
    .wr_full, .rd_empty, .rd_data_valid, .cmd_ack, .bresp_valid, .bresp,
    .accept, .HREADYOUT, .hresp, .wr_push, .rd_pop, .cmd_req
  );

  ahb_wr_buffer #(
    .AHB_DWIDTH(AHB_DWIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_wr_buf (
    .HCLK, .HRESETn, .HWDATA, .wr_push, .wr_pop,
    .wr_data, .wr_empty, .wr_full
  );

  ahb_rd_buffer #(
    .AHB_DWIDTH(AHB_DWIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_rd_buf (
    .HCLK, .HRESETn, .rd_push, .rd_push_data, .rd_pop,
    .rd_full, .rd_empty, .HRDATA, .rd_data_valid
  );

endmodule

`default_nettype wire

/* bench/tb_ahb_tasks.svh */
// AHB master, back-end model and directed tests
// Included into the bridge front end testbench module
`ifndef TB_AHB_TASKS_SVH
`define TB_AHB_TASKS_SVH

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    errors++;
  endtask

  task automatic report(input string what);
    $display("Error: %s", what);
    errors++;
  endtask

  task automatic start_test(output int e0);
    b_addr.delete();
    b_wdata.delete();
    b_write.delete();
    b_trans.delete();
    b_burst.delete();
    wr_exp.delete();
    rd_exp.delete();
    rd_got.delete();
    acc_q.delete();
    req_q.delete();
    resp_q.delete();
    errlow_q.delete();
    e0 = errors;
  endtask

  task automatic finish_test(input string name, input int e0);
    tests++;
    if (errors == e0) begin
      $display("Test %-14s ok", name);
    end else begin
      $display("Test %-14s %0d error(s)", name, errors - e0);
    end
  endtask

  // ------------------------------------------------------------
  // AHB master
  // ------------------------------------------------------------
  // Queue the beats of one transfer, SEQ addresses wrap where the burst does
  task automatic add_xfer(input logic wr, input logic [31:0] addr,
                          input ahb_bridge_pkg::hburst_e burst, input int beats);
    int          i;
    logic [31:0] a;
    logic [31:0] mask;
    logic [31:0] w;
    mask = beats * 4 - 1;
    for (i = 0; i < beats; i++) begin
      a = addr + 4 * i;
      if (burst inside {ahb_bridge_pkg::BURST_WRAP4, ahb_bridge_pkg::BURST_WRAP8,
                        ahb_bridge_pkg::BURST_WRAP16}) begin
        a = (addr & ~mask) | (a & mask);
      end
      w = {addr[15:0], 8'hA5, 8'(i)};  // Unique per address and beat
      b_addr.push_back(a);
      b_write.push_back(wr);
      b_burst.push_back(burst);
      b_trans.push_back((i == 0) ? ahb_bridge_pkg::TRANS_NONSEQ : ahb_bridge_pkg::TRANS_SEQ);
      b_wdata.push_back(wr ? w : '0);
      if (wr) begin
        wr_exp.push_back(w);
      end
    end
  endtask

  task automatic drive_beat(input int i);
    HSEL   = 1'b1;
    HADDR  = b_addr[i];
    HWRITE = b_write[i];
    HTRANS = b_trans[i];
    HBURST = b_burst[i];
    HSIZE  = 3'd2;       // Word transfers only
  endtask

  // Returns at the falling edge of a cycle with HREADY high
  task automatic wait_ready();
    int t;
    t       = 0;
    err_low = 1'b0;
    @(negedge HCLK);
    while (!HREADY) begin
      if (HRESP[0]) err_low = 1'b1;
      t++;
      if (t > TMO) abort_run("HREADYOUT stayed low");
      @(negedge HCLK);
    end
  endtask

  // Pipelined master, next address phase overlaps the current data phase
  task automatic run_bus();
    int n;
    int i;
    n = b_addr.size();
    @(posedge HCLK);
    #2 drive_beat(0);
    wait_ready();
    for (i = 0; i < n; i++) begin
      if (b_trans[i] == ahb_bridge_pkg::TRANS_NONSEQ) acc_q.push_back(cyc);
      @(posedge HCLK);
      #2;
      if (b_write[i]) HWDATA = b_wdata[i];
      if (i + 1 < n) begin
        drive_beat(i + 1);
      end else begin
        HSEL   = 1'b0;
        HTRANS = ahb_bridge_pkg::TRANS_IDLE;
      end
      wait_ready();
      if (!b_write[i]) rd_got.push_back(HRDATA);
      resp_q.push_back(HRESP[0]);
      errlow_q.push_back(err_low);
    end
  endtask

  // ------------------------------------------------------------
  // Back end
  // ------------------------------------------------------------
  task automatic wait_req(input logic level);
    int t;
    t = 0;
    @(negedge HCLK);
    while (cmd_req !== level) begin
      t++;
      if (t > TMO) abort_run("cmd_req never changed level");
      @(negedge HCLK);
    end
  endtask

  // One command: handshake, then data, then bresp for writes
  task automatic serve_cmd(input logic wr, input logic [31:0] addr, input int len,
                           input int gap, input ahb_bridge_pkg::axi_resp_e resp);
    int          t;
    int          k;
    logic [31:0] w;
    wait_req(1'b1);
    req_q.push_back(cyc);
    if (cmd_write !== wr) mismatch("cmd_write", cmd_write, wr);
    if (cmd_addr !== addr) mismatch("cmd_addr", cmd_addr, addr);
    if (cmd_size !== 3'd2) mismatch("cmd_size", cmd_size, 2);
    if (cmd_len !== ahb_bridge_pkg::beat_cnt_t'(len)) mismatch("cmd_len", cmd_len, len);
    repeat ({$random(seed)} % 3) @(posedge HCLK);  // Ack 1 to 3 cycles after req
    @(posedge HCLK);
    #2 cmd_ack = 1'b1;
    wait_req(1'b0);
    @(posedge HCLK);
    #2 cmd_ack = 1'b0;
    for (k = 0; k <= len; k++) begin
      t = 0;
      @(negedge HCLK);
      while (wr ? wr_empty : rd_full) begin
        t++;
        if (t > TMO) abort_run("back-end FIFO wait never ended");
        @(negedge HCLK);
      end
      @(posedge HCLK);
      #2;
      if (wr) begin
        wr_pop = 1'b1;
      end else begin
        w            = $random(seed);
        rd_push      = 1'b1;
        rd_push_data = w;
        rd_exp.push_back(w);
      end
      @(negedge HCLK);
      if (wr) begin
        w = wr_exp.pop_front();
        if (wr_data !== w) mismatch("wr_data", wr_data, w);
      end
      @(posedge HCLK);
      #2;
      wr_pop  = 1'b0;
      rd_push = 1'b0;
      if (wr) repeat (gap - 2) @(posedge HCLK);  // Pop every gap cycles
    end
    if (wr) begin
      @(posedge HCLK);
      #2;
      bresp_valid = 1'b1;
      bresp       = resp;
      @(posedge HCLK);
      #2;
      bresp_valid = 1'b0;
      bresp       = ahb_bridge_pkg::AXI_OKAY;
    end
  endtask

  // ------------------------------------------------------------
  // Common checks
  // ------------------------------------------------------------
  task automatic check_idle_outputs();
    @(negedge HCLK);
    if (HREADYOUT !== 1'b1) mismatch("HREADYOUT", HREADYOUT, 1);
    if (HRESP !== 2'b00) mismatch("HRESP", HRESP, 0);
    if (cmd_req !== 1'b0) mismatch("cmd_req", cmd_req, 0);
    if (dut0.wr_push !== 1'b0) mismatch("wr_push", dut0.wr_push, 0);
    if (dut0.rd_pop !== 1'b0) mismatch("rd_pop", dut0.rd_pop, 0);
    if (wr_empty !== 1'b1) mismatch("wr_empty", wr_empty, 1);
    if (rd_full !== 1'b0) mismatch("rd_full", rd_full, 0);
  endtask

  // cmd_req rises the cycle after the accepting address phase
  task automatic check_cmd_timing();
    int i;
    if (acc_q.size() != req_q.size()) report("command count differs from accepted transfers");
    for (i = 0; i < acc_q.size() && i < req_q.size(); i++) begin
      if (req_q[i] != acc_q[i] + 1) mismatch("cmd_req cycle", req_q[i], acc_q[i] + 1);
    end
  endtask

  task automatic compare_reads();
    int i;
    if (rd_got.size() != rd_exp.size()) report("read beat count differs from pushed words");
    for (i = 0; i < rd_got.size() && i < rd_exp.size(); i++) begin
      if (rd_got[i] !== rd_exp[i]) mismatch("HRDATA", rd_got[i], rd_exp[i]);
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_reset();
    int e0;
    start_test(e0);
    repeat (15) @(posedge HCLK);
    check_idle_outputs();
    @(posedge HCLK);
    #2 HRESETn = 1'b1;
    check_idle_outputs();  // First cycle out of reset
    finish_test("reset", e0);
  endtask

  task automatic test_single_write();
    int e0;
    start_test(e0);
    add_xfer(1'b1, 32'h0000_1004, ahb_bridge_pkg::BURST_SINGLE, 1);
    fork
      run_bus();
      serve_cmd(1'b1, 32'h0000_1004, 0, 2, ahb_bridge_pkg::AXI_OKAY);
    join
    check_cmd_timing();
    if (resp_q[0] !== 1'b0) mismatch("HRESP", resp_q[0], 0);
    finish_test("single write", e0);
  endtask

  // Slow pops fill the 4-deep FIFO and stall the master
  task automatic test_incr8_slow();
    int e0;
    start_test(e0);
    add_xfer(1'b1, 32'h0000_2000, ahb_bridge_pkg::BURST_INCR8, 8);
    fork
      run_bus();
      serve_cmd(1'b1, 32'h0000_2000, 7, 4, ahb_bridge_pkg::AXI_OKAY);
    join
    check_cmd_timing();
    if (resp_q[$] !== 1'b0) mismatch("HRESP", resp_q[$], 0);
    finish_test("incr8 slow", e0);
  endtask

  // Second write is accepted in the ERROR completing cycle
  task automatic test_write_error();
    int e0;
    start_test(e0);
    add_xfer(1'b1, 32'h0000_3000, ahb_bridge_pkg::BURST_SINGLE, 1);
    add_xfer(1'b1, 32'h0000_3010, ahb_bridge_pkg::BURST_SINGLE, 1);
    fork
      run_bus();
      begin
        serve_cmd(1'b1, 32'h0000_3000, 0, 2, ahb_bridge_pkg::AXI_SLVERR);
        serve_cmd(1'b1, 32'h0000_3010, 0, 2, ahb_bridge_pkg::AXI_OKAY);
      end
    join
    check_cmd_timing();
    if (errlow_q[0] !== 1'b1) report("no ERROR cycle with HREADYOUT low");
    if (resp_q[0] !== 1'b1) mismatch("HRESP", resp_q[0], 1);
    if (errlow_q[1] !== 1'b0) report("ERROR seen on the write after recovery");
    if (resp_q[1] !== 1'b0) mismatch("HRESP", resp_q[1], 0);
    finish_test("write error", e0);
  endtask

  task automatic test_reads();
    int e0;
    start_test(e0);
    add_xfer(1'b0, 32'h0000_4000, ahb_bridge_pkg::BURST_SINGLE, 1);
    add_xfer(1'b0, 32'h0000_4008, ahb_bridge_pkg::BURST_WRAP4, 4);
    fork
      run_bus();
      begin
        serve_cmd(1'b0, 32'h0000_4000, 0, 2, ahb_bridge_pkg::AXI_OKAY);
        serve_cmd(1'b0, 32'h0000_4008, 3, 2, ahb_bridge_pkg::AXI_OKAY);
      end
    join
    check_cmd_timing();
    compare_reads();
    finish_test("reads", e0);
  endtask

  // Undefined length INCR runs as one beat each way
  task automatic test_undef_incr();
    int e0;
    start_test(e0);
    add_xfer(1'b1, 32'h0000_5000, ahb_bridge_pkg::BURST_INCR, 1);
    add_xfer(1'b0, 32'h0000_5004, ahb_bridge_pkg::BURST_INCR, 1);
    fork
      run_bus();
      begin
        serve_cmd(1'b1, 32'h0000_5000, 0, 2, ahb_bridge_pkg::AXI_OKAY);
        serve_cmd(1'b0, 32'h0000_5004, 0, 2, ahb_bridge_pkg::AXI_OKAY);
      end
    join
    check_cmd_timing();
    compare_reads();
    if (resp_q[0] !== 1'b0) mismatch("HRESP", resp_q[0], 0);
    finish_test("undef incr", e0);
  endtask

`endif

/* bench/tb_ahb_to_axi_front.sv */
// Testbench for the AHB-to-AXI bridge front end
// AHB master and back-end models run directed tests against the DUT
`default_nettype none

module tb_ahb_to_axi_front;

  localparam int TMO = 300;  // Cycles any single wait may take

  logic                      HCLK;
  logic                      HRESETn;
  logic                      HSEL;
  logic [31:0]               HADDR;
  logic                      HWRITE;
  logic                      HREADY;
  ahb_bridge_pkg::htrans_e   HTRANS;
  logic [2:0]                HSIZE;
  ahb_bridge_pkg::hburst_e   HBURST;
  logic [31:0]               HWDATA;
  logic                      HREADYOUT;
  logic [1:0]                HRESP;
  logic [31:0]               HRDATA;
  logic [31:0]               cmd_addr;
  logic                      cmd_write;
  logic [2:0]                cmd_size;
  ahb_bridge_pkg::beat_cnt_t cmd_len;
  logic                      cmd_req;
  logic                      cmd_ack;
  logic [31:0]               wr_data;
  logic                      wr_empty;
  logic                      wr_pop;
  logic                      bresp_valid;
  ahb_bridge_pkg::axi_resp_e bresp;
  logic                      rd_push;
  logic [31:0]               rd_push_data;
  logic                      rd_full;

  // ------------------------------------------------------------
  // Bookkeeping shared by the master and back-end models
  // ------------------------------------------------------------
  int   seed = 21;
  int   errors;
  int   tests;
  int   cyc = 0;           // Cycle number, bumped on every rising edge
  logic err_low;           // ERROR seen while HREADYOUT low

  logic [31:0]             b_addr[$];   // One entry per beat on the bus
  logic [31:0]             b_wdata[$];
  logic                    b_write[$];
  ahb_bridge_pkg::htrans_e b_trans[$];
  ahb_bridge_pkg::hburst_e b_burst[$];
  logic [31:0]             wr_exp[$];   // Words the back end must pop
  logic [31:0]             rd_exp[$];   // Words the back end pushed
  logic [31:0]             rd_got[$];   // HRDATA seen by the master
  int                      acc_q[$];    // Address phase cycles of NONSEQ beats
  int                      req_q[$];    // First cycle with cmd_req high
  logic                    resp_q[$];   // HRESP at each beat's ready cycle
  logic                    errlow_q[$];

  assign HREADY = HREADYOUT;  // Loopback as in a single-slave system

  ahb_to_axi_front #(
    .AHB_AWIDTH(32),
    .AHB_DWIDTH(32),
    .FIFO_DEPTH(4)
  ) dut0 (.*);

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  always @(posedge HCLK) cyc <= cyc + 1;

  // Ends the run when a wait never completes
  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("Result: FAILED");
    $finish;
  endtask

  `include "tb_ahb_tasks.svh"

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    errors       = 0;
    tests        = 0;
    HRESETn      = 1'b0;
    HSEL         = 1'b0;
    HADDR        = '0;
    HWRITE       = 1'b0;
    HTRANS       = ahb_bridge_pkg::TRANS_IDLE;
    HSIZE        = 3'd2;
    HBURST       = ahb_bridge_pkg::BURST_SINGLE;
    HWDATA       = '0;
    cmd_ack      = 1'b0;
    wr_pop       = 1'b0;
    bresp_valid  = 1'b0;
    bresp        = ahb_bridge_pkg::AXI_OKAY;
    rd_push      = 1'b0;
    rd_push_data = '0;

    test_reset();         // Releases reset after 16 cycles
    test_single_write();
    test_incr8_slow();
    test_write_error();
    test_reads();
    test_undef_incr();

    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ahb_to_axi_front.f */
+incdir+bench
rtl/ahb_bridge_pkg.sv
rtl/ahb_cmd_capture.sv
rtl/ahb_access_fsm.sv
rtl/ahb_wr_buffer.sv
rtl/ahb_rd_buffer.sv
rtl/ahb_to_axi_front.sv
bench/tb_ahb_to_axi_front.sv

/* Bender.yml */
package:
  name: ahb_to_axi_front

sources:
  - rtl/ahb_bridge_pkg.sv
  - rtl/ahb_cmd_capture.sv
  - rtl/ahb_access_fsm.sv
  - rtl/ahb_wr_buffer.sv
  - rtl/ahb_rd_buffer.sv
  - rtl/ahb_to_axi_front.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_ahb_to_axi_front.sv
